/* common/smc_mac_pkg.sv */
// shared types and helpers for the multiple access controller
// size codes, data widths and the access-count arithmetic

package smc_mac_pkg;

  typedef logic [31:0] data_t;   // internal and external data word
  typedef logic [1:0]  size_t;   // transfer size or bus width code
  typedef logic [1:0]  count_t;  // accesses left after the current one

  localparam size_t SIZE_8  = 2'd0;
  localparam size_t SIZE_16 = 2'd1;
  localparam size_t SIZE_32 = 2'd2;  // code 3 decodes as 8 bits

  // bytes carried by a size code
  function automatic logic [2:0] size_bytes(size_t size);
    case (size)
      SIZE_16: return 3'd2;
      SIZE_32: return 3'd4;
      default: return 3'd1;  // 8 bit and the spare code
    endcase
  endfunction

  // accesses after the first one, zero when the bus is wide enough
  function automatic count_t accesses_needed(size_t xfer, size_t bus);
    logic [2:0] xfer_b;
    logic [2:0] bus_b;
    xfer_b = size_bytes(xfer);
    bus_b  = size_bytes(bus);
    if (xfer_b <= bus_b)
      return '0;
    return count_t'(xfer_b / bus_b - 3'd1);
  endfunction

  // ones over the low bytes of one bus-wide beat
  function automatic data_t width_mask(size_t size);
    return data_t'({32{1'b1}} >> (6'd32 - {size_bytes(size), 3'b000}));
  endfunction

  // bit offset of the byte lanes used by access number count
  function automatic logic [6:0] lane_shift(count_t count, size_t bus);
    logic [3:0] lanes;
    lanes = 4'(count) * 4'(size_bytes(bus));  // first byte lane
    return {lanes, 3'b000};
  endfunction

endpackage

/* verilog/access_counter.sv */
// transfer size store and access down-counter
// loads on valid_access, steps down on each smc_done, flags the last access

module access_counter #(
  parameter smc_mac_pkg::size_t bus_size = smc_mac_pkg::SIZE_8  // external width
) (
  input  logic                sys_clk28,
  input  logic                n_sys_reset28,
  input  logic                valid_access,   // first cycle of a new transfer
  input  smc_mac_pkg::size_t  xfer_size,      // valid with valid_access
  input  logic                smc_done,       // end of one external access
  output smc_mac_pkg::count_t access_count,   // accesses still to follow
  output logic                mac_done,       // last access in progress
  output smc_mac_pkg::size_t  cur_xfer_size,  // stored size
  output smc_mac_pkg::size_t  v_xfer_size     // size valid for whole transfer
);

  smc_mac_pkg::count_t num_accesses;  // load value for the counter

  //----------------------------------------------------------------------
  // size decode and store
  //----------------------------------------------------------------------

  always_comb
    num_accesses = smc_mac_pkg::accesses_needed(xfer_size, bus_size);

  always_ff @(posedge sys_clk28 or negedge n_sys_reset28)
  begin
    if (!n_sys_reset28)
      cur_xfer_size <= smc_mac_pkg::SIZE_8;
    else if (valid_access)
      cur_xfer_size <= xfer_size;  // held until next transfer
  end

  // live size in the request cycle, stored size after it
  assign v_xfer_size = valid_access ? xfer_size : cur_xfer_size;

  //----------------------------------------------------------------------
  // access counter
  //----------------------------------------------------------------------

  always_ff @(posedge sys_clk28 or negedge n_sys_reset28)
  begin
    if (!n_sys_reset28)
      access_count <= '0;
    else if (valid_access)
      access_count <= num_accesses;
    else if (smc_done && (access_count != '0))
      access_count <= access_count - smc_mac_pkg::count_t'(1);  // stops at zero
  end

  // zero count means this is the final access
  assign mac_done = (access_count == '0);

endmodule

/* read_assembler/read_assembler.sv */
// read word builder for transfers wider than the external bus
// narrow reads land in their byte lanes, the word goes out with replication

module read_assembler #(
  parameter smc_mac_pkg::size_t bus_size = smc_mac_pkg::SIZE_8  // external width
) (
  input  logic                sys_clk28,
  input  logic                n_sys_reset28,
  input  logic                latch_data,     // read data valid on data_smc
  input  smc_mac_pkg::data_t  data_smc,       // external read data
  input  smc_mac_pkg::count_t access_count,   // selects the lanes
  input  logic                mac_done,       // last access
  input  smc_mac_pkg::size_t  cur_xfer_size,  // stored transfer size
  output smc_mac_pkg::data_t  read_data       // word to internal bus
);

  localparam logic [2:0] bus_bytes = smc_mac_pkg::size_bytes(bus_size);
  localparam smc_mac_pkg::data_t bus_mask = smc_mac_pkg::width_mask(bus_size);

  smc_mac_pkg::data_t r_read_data;  // assembled word so far
  smc_mac_pkg::data_t lane_mask;    // lanes of this access
  smc_mac_pkg::data_t lane_data;    // new beat moved into its lanes
  smc_mac_pkg::data_t next_word;    // value stored on latch_data
  smc_mac_pkg::data_t src_word;     // before replication
  logic [6:0]         bit_base;     // bit offset of this access
  logic [2:0]         xfer_bytes;
  logic [2:0]         rep_bytes;    // replication width
  logic               wide_xfer;    // needs more than one access

  //----------------------------------------------------------------------
  // lane placement
  //----------------------------------------------------------------------

  always_comb
  begin
    xfer_bytes = smc_mac_pkg::size_bytes(cur_xfer_size);
    wide_xfer  = (xfer_bytes > bus_bytes);
    bit_base   = smc_mac_pkg::lane_shift(access_count, bus_size);
    lane_mask  = bus_mask << bit_base;
    lane_data  = (data_smc & bus_mask) << bit_base;  // only the low beat
    // narrow transfers keep the whole bus word
    if (wide_xfer)
      next_word = (r_read_data & ~lane_mask) | lane_data;
    else
      next_word = data_smc;
  end

  //----------------------------------------------------------------------
  // read data store
  //----------------------------------------------------------------------

  always_ff @(posedge sys_clk28 or negedge n_sys_reset28)
  begin
    if (!n_sys_reset28)
      r_read_data <= '0;
    else if (latch_data)
      r_read_data <= next_word;  // other lanes keep earlier beats
  end

  //----------------------------------------------------------------------
  // word to internal bus
  //----------------------------------------------------------------------

  always_comb
  begin
    // last beat goes straight through, saves a cycle
    if (latch_data && mac_done)
      src_word = next_word;
    else
      src_word = r_read_data;

    // transfer at least as wide as bus replicates at transfer width,
    // a narrower one just shows the bus-wide value
    rep_bytes = wide_xfer ? xfer_bytes : bus_bytes;

    case (rep_bytes)
      3'd1:    read_data = {4{src_word[7:0]}};   // byte in every lane
      3'd2:    read_data = {2{src_word[15:0]}};  // halfword in both halves
      default: read_data = src_word;             // full word
    endcase
  end

endmodule

/* verilog/write_lane_select.sv */
// write slice select for the external bus
// picks the lanes of the held write word that belong to this access

module write_lane_select #(
  parameter smc_mac_pkg::size_t bus_size = smc_mac_pkg::SIZE_8  // external width
) (
  input  smc_mac_pkg::data_t  write_data,    // held for the whole transfer
  input  smc_mac_pkg::count_t access_count,  // current access number
  output smc_mac_pkg::data_t  smc_data       // external write data
);

  localparam smc_mac_pkg::data_t bus_mask = smc_mac_pkg::width_mask(bus_size);

  logic [6:0]         bit_base;  // bit offset of this access
  smc_mac_pkg::data_t shifted;   // slice moved down to lane 0

  always_comb
  begin
    bit_base = smc_mac_pkg::lane_shift(access_count, bus_size);
    shifted  = write_data >> bit_base;  // high lanes first as the count runs down
    // a 32 bit bus has a zero count and a full mask, so the word goes out whole
    smc_data = shifted & bus_mask;      // upper lanes cleared
  end

endmodule

/* verilog/smc_mac_top.sv */
// top level of the multiple access controller
// counter, read builder and write select for a bus_size wide memory

module smc_mac_top #(
  parameter smc_mac_pkg::size_t bus_size = smc_mac_pkg::SIZE_8  // 8, 16 or 32 bit
) (
  input  logic                sys_clk28,
  input  logic                n_sys_reset28,
  input  logic                valid_access,   // new transfer pulse
  input  smc_mac_pkg::size_t  xfer_size,      // with valid_access
  input  logic                smc_done,       // end of each access
  input  logic                latch_data,     // read data valid
  input  smc_mac_pkg::data_t  data_smc,       // external read data
  input  smc_mac_pkg::data_t  write_data,     // internal write data
  output smc_mac_pkg::count_t access_count,
  output logic                mac_done,
  output smc_mac_pkg::size_t  v_xfer_size,
  output smc_mac_pkg::data_t  read_data,      // to internal bus
  output smc_mac_pkg::data_t  smc_data        // to external bus
);

  smc_mac_pkg::size_t cur_xfer_size;  // stored size for the read side

  access_counter #(
    .bus_size      (bus_size)
  ) u_access_counter (
    .sys_clk28     (sys_clk28),
    .n_sys_reset28 (n_sys_reset28),
    .valid_access  (valid_access),
    .xfer_size     (xfer_size),
    .smc_done      (smc_done),
    .access_count  (access_count),
    .mac_done      (mac_done),
    .cur_xfer_size (cur_xfer_size),
    .v_xfer_size   (v_xfer_size)
  );

  read_assembler #(
    .bus_size      (bus_size)
  ) u_read_assembler (
    .sys_clk28     (sys_clk28),
    .n_sys_reset28 (n_sys_reset28),
    .latch_data    (latch_data),
    .data_smc      (data_smc),
    .access_count  (access_count),
    .mac_done      (mac_done),
    .cur_xfer_size (cur_xfer_size),
    .read_data     (read_data)
  );

  write_lane_select #(
    .bus_size      (bus_size)
  ) u_write_lane_select (
    .write_data    (write_data),
    .access_count  (access_count),
    .smc_data      (smc_data)
  );

endmodule

/* tb/smc_mac_ref.svh */
// reference model, random source and compare task for the testbench
// included inside the testbench module and built from the byte-lane rules only

`ifndef SMC_MAC_REF_SVH
`define SMC_MAC_REF_SVH

logic [31:0] lfsr_state;  // seeded by the stimulus process

// fibonacci lfsr with taps 32 22 2 1 and one step per returned bit
function automatic logic [31:0] rand_bits(int n);
  logic [31:0] r;
  logic        fb;
  r = '0;
  for (int i = 0; i < n; i++)
  begin
    fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    r          = {r[30:0], fb};
  end
  return r;
endfunction

// byte count of a size code where the spare code reads as one byte
function automatic int bytes_of(logic [1:0] code);
  case (code)
    2'd1:    return 2;
    2'd2:    return 4;
    default: return 1;
  endcase
endfunction

// count loaded on valid_access is the access total minus one
function automatic logic [1:0] load_count(logic [1:0] size, int b);
  int n_acc;
  n_acc = bytes_of(size) / b;
  if (n_acc < 1)
    n_acc = 1;  // narrow transfer still takes one access
  return 2'(n_acc - 1);
endfunction

// bytes c*b to c*b+b-1 of the write word moved down to lane 0
function automatic logic [31:0] write_slice(logic [31:0] w, int c, int b);
  logic [31:0] r;
  r = '0;
  for (int k = 0; k < b; k++)
    r = r | (((w >> ((c * b + k) * 8)) & 32'hff) << (k * 8));
  return r;
endfunction

// word seen on the internal bus after the last access
function automatic logic [31:0] assembled_read(logic [1:0] size, int b, logic [31:0] reads [4]);
  int          n;
  int          rep;
  logic [31:0] word;
  n    = bytes_of(size);
  word = '0;
  if (n <= b)
    word = reads[0];  // single access keeps the whole bus word
  else
    for (int c = 0; c < n / b; c++)
      for (int k = 0; k < b; k++)
        word = word | (((reads[2'(c)] >> (k * 8)) & 32'hff) << ((c * b + k) * 8));
  rep = (n > b) ? n : b;
  case (rep)
    1:       return {4{word[7:0]}};
    2:       return {2{word[15:0]}};
    default: return word;
  endcase
endfunction

// one compare point for every check
task automatic check_value(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
  if (expected !== actual)
  begin
    $display("mismatch %s expected %h actual %h", what, expected, actual);
    $display("Test failed");
    $fatal(1, "run stopped on a wrong value");
  end
endtask

`endif

/* tb/smc_mac_tb.sv */
// testbench for smc_mac_top on an 8 bit external bus
// random transfers with per-access checks of count, write slice and read word

module smc_mac_tb;

  localparam logic [1:0] bus_code        = 2'd0;  // 8 bit memory
  localparam int         bus_bytes       = 1;     // matches bus_code
  localparam int         num_xfers       = 40;
  localparam int         cycles_per_xfer = 12;    // worst case is 11
  localparam int         clk_period      = 8;
  localparam int         watchdog_time   = num_xfers * cycles_per_xfer * clk_period;

  logic        sys_clk28;
  logic        n_sys_reset28;
  logic        valid_access;
  logic [1:0]  xfer_size;
  logic        smc_done;
  logic        latch_data;
  logic [31:0] data_smc;
  logic [31:0] write_data;
  logic [1:0]  access_count;
  logic        mac_done;
  logic [1:0]  v_xfer_size;
  logic [31:0] read_data;
  logic [31:0] smc_data;

  // expected values set after a rising edge and read at the falling edge
  logic        chk_en   = 1'b0;
  logic        chk_smc  = 1'b0;
  logic        chk_read = 1'b0;
  logic [1:0]  exp_count;
  logic        exp_done;
  logic [1:0]  exp_vsize;
  logic [31:0] exp_smc;
  logic [31:0] exp_read;
  string       test_name;

  `include "smc_mac_ref.svh"

  smc_mac_top #(
    .bus_size      (bus_code)
  ) u_smc_mac_top (
    .sys_clk28     (sys_clk28),
    .n_sys_reset28 (n_sys_reset28),
    .valid_access  (valid_access),
    .xfer_size     (xfer_size),
    .smc_done      (smc_done),
    .latch_data    (latch_data),
    .data_smc      (data_smc),
    .write_data    (write_data),
    .access_count  (access_count),
    .mac_done      (mac_done),
    .v_xfer_size   (v_xfer_size),
    .read_data     (read_data),
    .smc_data      (smc_data)
  );

  initial
  begin
    sys_clk28 = 1'b0;
    forever #(clk_period / 2) sys_clk28 = ~sys_clk28;
  end

  //----------------------------------------------------------------------
  // one transfer with a request cycle, gap and strobe per access and a hold
  //----------------------------------------------------------------------

  task automatic run_transfer(input int idx);
    logic [1:0]  size;
    logic [31:0] wdata;
    logic [31:0] reads [4];
    int          n;
    for (int i = 0; i < 4; i++)
      reads[i] = '0;
    do
      size = 2'(rand_bits(2));
    while (size == 2'd3);  // codes 0 to 2 only
    wdata     = rand_bits(32);
    n         = int'(load_count(size, bus_bytes));
    test_name = $sformatf("xfer%0d_size%0d", idx, size);
    valid_access <= 1'b1;
    xfer_size    <= size;
    write_data   <= wdata;
    exp_vsize = size;  // live size in the request cycle
    exp_count = 2'd0;
    exp_done  = 1'b1;
    chk_smc   = 1'b0;
    @(posedge sys_clk28);
    valid_access <= 1'b0;
    xfer_size    <= 2'(rand_bits(2));  // stored size must win now
    chk_read = 1'b0;
    for (int c = n; c >= 0; c--)
    begin
      smc_done   <= 1'b0;  // gap cycle with the count held
      latch_data <= 1'b0;
      data_smc   <= rand_bits(32);
      exp_count = 2'(c);
      exp_done  = (c == 0);
      exp_smc   = write_slice(wdata, c, bus_bytes);
      chk_smc   = 1'b1;
      @(posedge sys_clk28);
      reads[2'(c)] = rand_bits(32);  // upper bytes are noise
      smc_done   <= 1'b1;
      latch_data <= 1'b1;
      data_smc   <= reads[2'(c)];
      if (c == 0)
      begin
        exp_read = assembled_read(size, bus_bytes, reads);
        chk_read = 1'b1;  // bypass in the last access
      end
      @(posedge sys_clk28);
    end
    smc_done   <= 1'b0;
    latch_data <= 1'b0;
    data_smc   <= rand_bits(32);
    exp_count = 2'd0;
    exp_done  = 1'b1;
    repeat (2) @(posedge sys_clk28);  // read word must hold
  endtask

  // stimulus
  initial
  begin
    n_sys_reset28 = 1'b0;
    valid_access  = 1'b0;
    xfer_size     = 2'd0;
    smc_done      = 1'b0;
    latch_data    = 1'b0;
    data_smc      = '0;
    write_data    = '0;
    lfsr_state    = 32'h25d82aca;
    repeat (2) @(posedge sys_clk28);
    n_sys_reset28 <= 1'b1;
    @(posedge sys_clk28);
    test_name = "after_reset";  // idle state with a zero count
    exp_count = 2'd0;
    exp_done  = 1'b1;
    exp_vsize = 2'd0;
    chk_en    = 1'b1;
    @(posedge sys_clk28);
    for (int t = 0; t < num_xfers; t++)
      run_transfer(t);
    chk_en = 1'b0;
    @(posedge sys_clk28);
    $display("Test completed successfully");
    $finish;
  end

  // compare at the falling edge away from input changes
  initial
  begin
    forever
    begin
      @(negedge sys_clk28);
      if (chk_en)
      begin
        check_value({test_name, " access_count"}, 32'(exp_count), 32'(access_count));
        check_value({test_name, " mac_done"}, 32'(exp_done), 32'(mac_done));
        check_value({test_name, " v_xfer_size"}, 32'(exp_vsize), 32'(v_xfer_size));
        if (chk_smc)
          check_value({test_name, " smc_data"}, exp_smc, smc_data);
        if (chk_read)
          check_value({test_name, " read_data"}, exp_read, read_data);
      end
    end
  end

  // watchdog
  initial
  begin
    #(watchdog_time);
    $display("watchdog expired before all transfers were run");
    $display("Test failed");
    $fatal(1, "timeout");
  end

endmodule

/* smc_mac.f */
+incdir+tb
common/smc_mac_pkg.sv
verilog/access_counter.sv
read_assembler/read_assembler.sv
verilog/write_lane_select.sv
verilog/smc_mac_top.sv
tb/smc_mac_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the smc_mac testbench with Verilator
# exit status is the simulator's, nonzero on any failure

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 \
  --top-module smc_mac_tb \
  -f smc_mac.f \
  --Mdir obj_dir \
  -o smc_mac_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/smc_mac_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

echo "simulation finished with status 0"
exit 0
